//--- Makefile
# Verilator flow for the SRAM wrapper testbench

TOP       ?= tb_sram_wrapper
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a run cut short has no pass line either
run: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
sram_cfg_pkg.sv
sram_bus_pkg.sv
sram_macro.sv
sram_req_frontend.sv
sram_bank_array.sv
sram_wrapper.sv
tb_sram_wrapper.sv

//--- sram_bank_array.sv
`timescale 1ns/1ns

module sram_bank_array
  import sram_cfg_pkg::*;
  import sram_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       sleep_i,
  input  logic       acc_i,
  input  macro_req_t mreq_i,
  output logic       rsp_valid_o,
  output data_t      rdata_o
);

  logic [num_banks-1:0] bank_cs;
  data_t                bank_rdata [num_banks];

  logic      rd_valid_q;
  bank_sel_t rd_bank_q;

  // ----------------------------------------------------------
  // Chip select decode
  // ----------------------------------------------------------

  // Top address bits pick one sub-macro
  always_comb begin
    bank_cs = '0;
    if (acc_i) begin
      bank_cs[mreq_i.bank] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Sub-macros
  // ----------------------------------------------------------

  for (genvar b = 0; b < num_banks; b++) begin : gen_bank
    sram_macro #(
      .bank_index (b)
    ) u_macro (
      .clk_i    (clk_i),
      .cs_i     (bank_cs[b]),
      .we_i     (mreq_i.we),
      .row_i    (mreq_i.row),
      .col_i    (mreq_i.col),
      .wdata_i  (mreq_i.wdata),
      .mask_i   (mreq_i.mask),
      .retain_i (sleep_i),
      .rdata_o  (bank_rdata[b])
    );
  end

  // ----------------------------------------------------------
  // Read response
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= acc_i & ~mreq_i.we;
    end
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (acc_i && !mreq_i.we) begin
      rd_bank_q <= mreq_i.bank;
    end
  end

  assign rsp_valid_o = rd_valid_q;
  assign rdata_o     = bank_rdata[rd_bank_q];

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  a_cs_onehot: assert property (
    @(posedge clk_i) $onehot0(bank_cs)
  ) else begin
    $error("sram_bank_array: more than one chip select active");
  end

endmodule

//--- sram_bus_pkg.sv
package sram_bus_pkg;

  import sram_cfg_pkg::*;

  // ----------------------------------------------------------
  // Data path types
  // ----------------------------------------------------------

  typedef logic [data_width-1:0] data_t;
  typedef logic [num_bytes-1:0]  be_t;
  typedef logic [data_width-1:0] bit_mask_t;

  // ----------------------------------------------------------
  // Request formats
  // ----------------------------------------------------------

  // Core side request
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } sram_req_t;

  // Array side request, address already split
  typedef struct packed {
    bank_sel_t bank;
    row_t      row;
    col_t      col;
    logic      we;
    data_t     wdata;
    bit_mask_t mask;
  } macro_req_t;

endpackage

//--- sram_cfg_pkg.sv
package sram_cfg_pkg;

  // ----------------------------------------------------------
  // Array geometry
  // ----------------------------------------------------------

  // Whole memory as seen by the core
  localparam int unsigned num_words  = 8192;
  localparam int unsigned data_width = 32;
  localparam int unsigned num_bytes  = data_width / 8;

  // One tiled sub-macro
  localparam int unsigned bank_words = 1024;
  localparam int unsigned num_banks  = num_words / bank_words;
  localparam int unsigned col_mux    = 4;

  // ----------------------------------------------------------
  // Address fields
  // ----------------------------------------------------------

  // Word address is split as {bank, row, col}
  localparam int unsigned addr_width = $clog2(num_words);
  localparam int unsigned bank_width = $clog2(num_banks);
  localparam int unsigned col_width  = $clog2(col_mux);
  localparam int unsigned row_width  = $clog2(bank_words / col_mux);

  // Word address into the full memory
  typedef logic [addr_width-1:0] addr_t;

  // Sub-macro index, top address bits
  typedef logic [bank_width-1:0] bank_sel_t;

  // Row within a sub-macro
  typedef logic [row_width-1:0] row_t;

  // Column mux select within a row
  typedef logic [col_width-1:0] col_t;

endpackage

//--- sram_macro.sv
`timescale 1ns/1ns

module sram_macro
  import sram_cfg_pkg::*;
  import sram_bus_pkg::*;
#(
  parameter int unsigned bank_index = 0
) (
  input  logic      clk_i,
  input  logic      cs_i,
  input  logic      we_i,
  input  row_t      row_i,
  input  col_t      col_i,
  input  data_t     wdata_i,
  input  bit_mask_t mask_i,
  input  logic      retain_i,
  output data_t     rdata_o
);

  localparam int unsigned num_rows = bank_words / col_mux;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  // Each row holds col_mux words side by side
  data_t mem_q [num_rows][col_mux];

  logic  access;
  logic  do_write;
  logic  do_read;
  data_t cur_word;
  data_t new_word;

  // Array is gated while retaining, contents stay put
  assign access   = cs_i & ~retain_i;
  assign do_write = access & we_i;
  assign do_read  = access & ~we_i;

  assign cur_word = mem_q[row_i][col_i];

  // Only masked bits take the new value
  assign new_word = (cur_word & ~mask_i) | (wdata_i & mask_i);

  // ----------------------------------------------------------
  // Write and read ports
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[row_i][col_i] <= new_word;
    end
  end

  // Output holds its value between reads
  always_ff @(posedge clk_i) begin
    if (do_read) begin
      rdata_o <= cur_word;
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  // Requests must be held off upstream while in retention
  a_no_cs_in_retention: assert property (
    @(posedge clk_i) !(cs_i && retain_i)
  ) else begin
    $error("sram_macro %0d: chip select during retention", bank_index);
  end

endmodule

//--- sram_req_frontend.sv
`timescale 1ns/1ns

module sram_req_frontend
  import sram_cfg_pkg::*;
  import sram_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       sleep_i,
  input  logic       req_valid_i,
  input  sram_req_t  req_i,
  output logic       req_ready_o,
  output logic       acc_o,
  output macro_req_t mreq_o
);

  bit_mask_t bit_mask;

  // ----------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------

  // Only retention can stall the port
  assign req_ready_o = ~sleep_i;
  assign acc_o       = req_valid_i & req_ready_o;

  // ----------------------------------------------------------
  // Byte enable to bit mask
  // ----------------------------------------------------------

  for (genvar i = 0; i < num_bytes; i++) begin : gen_bit_mask
    assign bit_mask[i*8 +: 8] = {8{req_i.be[i]}};
  end

  // ----------------------------------------------------------
  // Address split and request build
  // ----------------------------------------------------------

  always_comb begin
    {mreq_o.bank, mreq_o.row, mreq_o.col} = req_i.addr;
    mreq_o.we    = req_i.we;
    mreq_o.wdata = req_i.wdata;
    mreq_o.mask  = bit_mask;
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  // A stalled request stays up with the same payload
  a_valid_held: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (req_valid_i && !req_ready_o) |=> req_valid_i
  ) else begin
    $error("sram_req_frontend: valid dropped before transfer");
  end

  a_payload_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (req_valid_i && !req_ready_o) |=> $stable(req_i)
  ) else begin
    $error("sram_req_frontend: payload changed before transfer");
  end

endmodule

//--- sram_wrapper.sv
`timescale 1ns/1ns

module sram_wrapper
  import sram_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      sleep_i,
  input  logic      req_valid_i,
  input  sram_req_t req_i,
  output logic      req_ready_o,
  output logic      rsp_valid_o,
  output data_t     rdata_o
);

  logic       acc;
  macro_req_t mreq;

  // ----------------------------------------------------------
  // Request path
  // ----------------------------------------------------------

  sram_req_frontend u_frontend (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .sleep_i     (sleep_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .acc_o       (acc),
    .mreq_o      (mreq)
  );

  // ----------------------------------------------------------
  // Banked array
  // ----------------------------------------------------------

  sram_bank_array u_bank_array (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .sleep_i     (sleep_i),
    .acc_i       (acc),
    .mreq_i      (mreq),
    .rsp_valid_o (rsp_valid_o),
    .rdata_o     (rdata_o)
  );

endmodule

//--- tb_sram_wrapper.sv
`timescale 1ns/1ns

module tb_sram_wrapper
  import sram_cfg_pkg::*;
  import sram_bus_pkg::*;
();

  localparam int n_full       = 64;
  localparam int n_part       = 96;
  localparam int pool_sz      = 16;
  localparam int n_order      = 64;
  localparam int n_gap        = 64;
  localparam int n_keep       = 16;
  localparam int sleep_cycles = 4;
  localparam int total_reqs   = 2 * n_full + n_part + pool_sz + 2 * n_order + n_gap
                                + 2 * n_keep + 1;
  localparam int watchdog_ns  = total_reqs * 100 * 4;

  logic      clk;
  logic      reset;
  logic      sleep;
  logic      req_valid;
  sram_req_t req;
  logic      req_ready;
  logic      rsp_valid;
  data_t     rdata;

  // Reference memory and the bytes written so far per word
  data_t  model_mem [addr_t];
  be_t    model_written [addr_t];
  addr_t  pool [pool_sz];
  addr_t  saved_addr [$];

  integer seed;
  string  cur_test;
  int     test_checks;
  int     test_errors;
  int     total_checks;
  int     total_errors;

  sram_wrapper dut0 (
    .clk_i       (clk),
    .reset_i     (reset),
    .sleep_i     (sleep),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rdata_o     (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic bit_mask_t bytes_to_bits(be_t be);
    bit_mask_t m;
    for (int i = 0; i < num_bytes; i++) begin
      m[i*8 +: 8] = be[i] ? 8'hff : 8'h00;
    end
    return m;
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic addr_t rand_addr_in_bank(int bank);
    logic [31:0] r;
    r = $random(seed);
    return {bank[bank_width-1:0], r[addr_width-bank_width-1:0]};
  endfunction

  function automatic sram_req_t make_req(logic we, addr_t a, data_t d, be_t be);
    sram_req_t r;
    r.we    = we;
    r.addr  = a;
    r.wdata = d;
    r.be    = be;
    return r;
  endfunction

  function automatic sram_req_t rand_req(addr_t a);
    logic [31:0] r;
    r = $random(seed);
    return make_req(r[0], a, data_t'($random(seed)), r[num_bytes:1]);
  endfunction

  task automatic model_write(addr_t a, data_t d, be_t be);
    data_t w;
    be_t   m;
    w = model_mem.exists(a) ? model_mem[a] : '0;
    m = model_written.exists(a) ? model_written[a] : '0;
    for (int i = 0; i < num_bytes; i++) begin
      if (be[i]) begin
        w[i*8 +: 8] = d[i*8 +: 8];
        m[i]        = 1'b1;
      end
    end
    model_mem[a]     = w;
    model_written[a] = m;
  endtask

  task automatic check_bit(string what, logic expected, logic actual);
    test_checks++;
    assert (actual === expected) else begin
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_word(data_t expected, data_t actual, bit_mask_t m);
    test_checks++;
    assert ((actual & m) === (expected & m)) else begin
      $display("MISMATCH %s rdata: expected %h, actual %h (mask %h)",
               cur_test, expected & m, actual & m, m);
      test_errors++;
    end
  endtask

  // One clock from falling edge to falling edge
  task automatic advance(output bit accepted);
    logic  exp_rsp;
    data_t exp_word;
    be_t   exp_bytes;
    @(posedge clk);
    check_bit("req_ready", !sleep, req_ready);
    accepted  = req_valid && !sleep;
    exp_rsp   = accepted && !req.we;
    exp_word  = '0;
    exp_bytes = '0;
    if (exp_rsp && model_mem.exists(req.addr)) begin
      exp_word  = model_mem[req.addr];
      exp_bytes = model_written[req.addr];
    end
    if (accepted && req.we) begin
      model_write(req.addr, req.wdata, req.be);
    end
    @(negedge clk);
    check_bit("rsp_valid", exp_rsp, rsp_valid);
    if (exp_rsp) begin
      check_word(exp_word, rdata, bytes_to_bits(exp_bytes));
    end
  endtask

  task automatic send(sram_req_t r);
    bit accepted;
    req_valid = 1'b1;
    req       = r;
    accepted  = 1'b0;
    while (!accepted) begin
      advance(accepted);
    end
  endtask

  // Payload is put up early and held while valid is low
  task automatic gap_send(int gap, sram_req_t r);
    bit accepted;
    req_valid = 1'b0;
    req       = r;
    repeat (gap) advance(accepted);
    send(r);
  endtask

  task automatic idle(int cycles);
    bit accepted;
    req_valid = 1'b0;
    repeat (cycles) advance(accepted);
  endtask

  task automatic finish_test();
    $display("%-10s %0d checks, %0d errors", cur_test, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    addr_t a;
    bit    accepted;

    seed         = 32'hacea_b483;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    total_errors = 0;
    reset        = 1'b1;
    sleep        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    cur_test = "reset";
    check_bit("rsp_valid", 1'b0, rsp_valid);
    idle(2);
    finish_test();

    // Full words spread over every bank
    cur_test = "full_word";
    for (int i = 0; i < n_full; i++) begin
      a = rand_addr_in_bank(i % num_banks);
      saved_addr.push_back(a);
      send(make_req(1'b1, a, data_t'($random(seed)), '1));
    end
    foreach (saved_addr[i]) begin
      send(make_req(1'b0, saved_addr[i], '0, '0));
    end
    idle(1);
    finish_test();

    cur_test = "partial";
    for (int i = 0; i < pool_sz; i++) begin
      pool[i] = rand_addr_in_bank(i % num_banks);
    end
    for (int i = 0; i < n_part; i++) begin
      send(rand_req(pool[rand_below(pool_sz)]));
    end
    for (int i = 0; i < pool_sz; i++) begin
      send(make_req(1'b0, pool[i], '0, '0));
    end
    idle(1);
    finish_test();

    // Write then read of one address on consecutive edges
    cur_test = "ordering";
    for (int i = 0; i < n_order; i++) begin
      a = pool[rand_below(pool_sz)];
      if (rand_below(2) == 1) begin
        send(make_req(1'b1, a, data_t'($random(seed)), be_t'(rand_below(16))));
      end
      send(make_req(1'b0, a, '0, '0));
    end
    idle(1);
    finish_test();

    cur_test = "gaps";
    for (int i = 0; i < n_gap; i++) begin
      gap_send(rand_below(3), rand_req(pool[rand_below(pool_sz)]));
    end
    idle(1);
    finish_test();

    cur_test = "sleep";
    saved_addr.delete();
    for (int i = 0; i < n_keep; i++) begin
      a = rand_addr_in_bank(i % num_banks);
      saved_addr.push_back(a);
      send(make_req(1'b1, a, data_t'($random(seed)), '1));
    end
    req_valid = 1'b1;
    req       = make_req(1'b0, saved_addr[0], '0, '0);
    sleep     = 1'b1;
    repeat (sleep_cycles) advance(accepted);
    sleep = 1'b0;
    send(req);
    foreach (saved_addr[i]) begin
      send(make_req(1'b0, saved_addr[i], '0, '0));
    end
    idle(1);
    finish_test();

    $display("checks %0d, errors %0d", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
